/* Bender.yml */
package:
  name: dcache_subsystem

sources:
  - design/dcache_pkg.sv
  - design/line_mem_if.sv
  - design/dcache_store.sv
  - design/dcache_ctrl.sv
  - design/data_cache.sv
  - design/line_memory.sv
  - design/cache_subsystem_top.sv
  - target: test
    files:
      - bench/cache_checker.sv
      - bench/tb_top.sv

/* bench/cache_checker.sv */
module cache_checker import dcache_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         write_en,
    input  access_size_t type_control,
    input  addr_t        addr,
    input  word_t        din,
    input  word_t        dout,
    input  logic         stall,
    input  int           test_id,
    input  logic         test_done,
    output int           tests_passed,
    output int           tests_failed,
    output int           check_count,
    output int           error_count
);
    timeunit 1ns;
    timeprecision 1ps;

    // byte image of the 64 KB that line_memory decodes
    logic [7:0] shadow [65536];
    int         test_checks;
    int         test_errors;

    initial begin
        for (int i = 0; i < 65536; i++) begin
            shadow[i] = 8'h00;
        end
        tests_passed = 0;
        tests_failed = 0;
        check_count  = 0;
        error_count  = 0;
        test_checks  = 0;
        test_errors  = 0;
    end

    // halves and words ignore the low address bits
    function automatic logic [15:0] aligned_base(addr_t a, access_size_t size);
        case (size)
            size_byte: return a[15:0];
            size_half: return {a[15:1], 1'b0};
            default:   return {a[15:2], 2'b00};
        endcase
    endfunction

    // little endian, zero extended
    function automatic word_t expected_load(addr_t a, access_size_t size);
        logic [15:0] base;
        base = aligned_base(a, size);
        case (size)
            size_byte: return {24'h0, shadow[base]};
            size_half: return {16'h0, shadow[base + 1], shadow[base]};
            default:   return {shadow[base + 3], shadow[base + 2], shadow[base + 1], shadow[base]};
        endcase
    endfunction

    task automatic apply_store(addr_t a, access_size_t size, word_t data);
        logic [15:0] base;
        int          nbytes;
        base   = aligned_base(a, size);
        nbytes = (size == size_byte) ? 1 : (size == size_half) ? 2 : 4;
        for (int i = 0; i < nbytes; i++) begin
            shadow[base + i] = data[i*8 +: 8];
        end
    endtask

    task automatic record_check(logic failed);
        check_count++;
        test_checks++;
        if (failed) begin
            error_count++;
            test_errors++;
        end
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            if (write_en || type_control != size_none) begin
                if (!stall && write_en) begin
                    apply_store(addr, type_control, din);
                end else if (!stall) begin
                    record_check(dout !== expected_load(addr, type_control));
                    if (dout !== expected_load(addr, type_control)) begin
                        $display("CHECK FAILED at %0t: load size %0d addr %h expected %h got %h",
                                 $time, type_control, addr,
                                 expected_load(addr, type_control), dout);
                    end
                end
            end else begin
                // no access present, so no stall either
                record_check(stall !== 1'b0);
                if (stall !== 1'b0) begin
                    $display("CHECK FAILED at %0t: stall high in an idle cycle", $time);
                end
            end
            if (test_done) begin
                if (test_errors == 0) begin
                    tests_passed++;
                end else begin
                    tests_failed++;
                end
                $display("test %0d %s: %0d checks, %0d errors", test_id,
                         (test_errors == 0) ? "passed" : "failed", test_checks, test_errors);
                test_checks = 0;
                test_errors = 0;
            end
        end
    end

endmodule

/* bench/tb_top.sv */
module tb_top import dcache_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic [7:0]   test;
        logic         we;
        access_size_t size;
        addr_t        addr;
        word_t        data;
    } entry_t;

    logic         clk;
    logic         rst;
    logic         write_en;
    access_size_t type_control;
    addr_t        addr;
    word_t        din;
    word_t        dout;
    logic         stall;
    int           test_id;
    logic         test_done;
    int           tests_passed;
    int           tests_failed;
    int           check_count;
    int           error_count;
    entry_t       table_q [$];

    cache_subsystem_top #(.MEM_LATENCY(3)) dut (
        .clk (clk), .rst (rst), .write_en (write_en), .type_control (type_control),
        .addr (addr), .din (din), .dout (dout), .stall (stall)
    );

    cache_checker u_checker (
        .clk (clk), .rst (rst), .write_en (write_en), .type_control (type_control),
        .addr (addr), .din (din), .dout (dout), .stall (stall),
        .test_id (test_id), .test_done (test_done), .tests_passed (tests_passed),
        .tests_failed (tests_failed), .check_count (check_count), .error_count (error_count)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic add_entry(int test, logic we, access_size_t size, addr_t a, word_t d);
        entry_t e;
        e.test = test[7:0];
        e.we   = we;
        e.size = size;
        e.addr = a;
        e.data = d;
        table_q.push_back(e);
    endtask

    task automatic build_table();
        // word store, miss then hits
        add_entry(1, 1, size_word, 32'h0040, $urandom());
        add_entry(1, 0, size_word, 32'h0040, 0);
        add_entry(1, 1, size_word, 32'h0044, $urandom());
        add_entry(1, 0, size_word, 32'h0044, 0);
        add_entry(1, 0, size_word, 32'h0040, 0);
        // byte and half merges into one word
        add_entry(2, 1, size_word, 32'h0200, $urandom());
        for (int off = 0; off < 4; off++) begin
            add_entry(2, 1, size_byte, 32'h0200 + off, $urandom());
            add_entry(2, 0, size_word, 32'h0200, 0);
        end
        add_entry(2, 1, size_half, 32'h0202, $urandom());
        add_entry(2, 1, size_half, 32'h0209, $urandom());
        for (int off = 0; off < 4; off++) begin
            add_entry(2, 0, size_byte, 32'h0200 + off, 0);
            add_entry(2, 0, size_half, 32'h0200 + off, 0);
        end
        add_entry(2, 0, size_word, 32'h0208, 0);
        // never written, several sets
        for (int s = 0; s < 4; s++) begin
            add_entry(3, 0, size_word, 32'h4000 + s * 32'h30, 0);
            add_entry(3, 0, size_byte, 32'h4005 + s * 32'h30, 0);
        end
        // three tags on set 0x30, then three on set 0x50 with one kept recent
        for (int t = 0; t < 3; t++) begin
            add_entry(4, 1, size_word, 32'h0300 + t * 32'h800, $urandom());
            add_entry(4, 1, size_word, 32'h0308 + t * 32'h800, $urandom());
        end
        for (int t = 0; t < 3; t++) begin
            add_entry(4, 0, size_word, 32'h0300 + t * 32'h800, 0);
            add_entry(4, 0, size_word, 32'h0308 + t * 32'h800, 0);
        end
        add_entry(5, 1, size_word, 32'h0500, $urandom());
        add_entry(5, 1, size_word, 32'h0d00, $urandom());
        add_entry(5, 0, size_word, 32'h0500, 0);
        add_entry(5, 1, size_word, 32'h0d04, $urandom());
        add_entry(5, 0, size_word, 32'h0500, 0);
        add_entry(5, 1, size_word, 32'h1500, $urandom());
        add_entry(5, 0, size_word, 32'h0500, 0);
        add_entry(5, 0, size_word, 32'h0d00, 0);
        add_entry(5, 0, size_word, 32'h0d04, 0);
        add_entry(5, 0, size_word, 32'h1500, 0);
        // idle cycles, then reread
        for (int k = 0; k < 4; k++) begin
            add_entry(6, 0, size_none, 32'h0040, $urandom());
        end
        add_entry(6, 0, size_word, 32'h0040, 0);
        add_entry(6, 0, size_word, 32'h0300, 0);
        add_entry(6, 0, size_half, 32'h1302, 0);
        add_entry(6, 0, size_word, 32'h0d00, 0);
    endtask

    task automatic wait_accept(output logic ok);
        int cycles;
        ok     = 1'b0;
        cycles = 0;
        while (!ok && cycles < 200) begin
            @(posedge clk);
            cycles++;
            ok = !stall;
        end
    endtask

    initial begin
        int   seed_init;
        logic ok;
        logic timed_out;
        rst          = 1'b1;
        write_en     = 1'b0;
        type_control = size_none;
        addr         = '0;
        din          = '0;
        test_id      = 0;
        test_done    = 1'b0;
        timed_out    = 1'b0;
        seed_init    = $urandom(32'hbd630a4e);
        build_table();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < table_q.size() && !timed_out; i++) begin
            @(negedge clk);
            test_done    = 1'b0;
            test_id      = table_q[i].test;
            write_en     = table_q[i].we;
            type_control = table_q[i].size;
            addr         = table_q[i].addr;
            din          = table_q[i].data;
            wait_accept(ok);
            if (!ok) begin
                $display("timeout: stall stayed high for 200 cycles in test %0d at address %h",
                         test_id, addr);
                timed_out = 1'b1;
            end else begin
                // idle cycle, which also closes a finished test
                @(negedge clk);
                write_en     = 1'b0;
                type_control = size_none;
                test_done    = (i == table_q.size() - 1) || (table_q[i + 1].test != test_id);
                @(posedge clk);
            end
        end
        @(negedge clk);
        test_done = 1'b0;
        $display("tests passed %0d, tests failed %0d, checks %0d, errors %0d",
                 tests_passed, tests_failed, check_count, error_count);
        if (timed_out || error_count != 0 || tests_failed != 0) begin
            $display("FAIL: see errors above");
        end else begin
            $display("PASS: all tests");
        end
        $finish;
    end

endmodule

/* compile.f */
design/dcache_pkg.sv
design/line_mem_if.sv
design/dcache_store.sv
design/dcache_ctrl.sv
design/data_cache.sv
design/line_memory.sv
design/cache_subsystem_top.sv
bench/cache_checker.sv
bench/tb_top.sv

/* design/cache_subsystem_top.sv */
module cache_subsystem_top import dcache_pkg::*; #(
    parameter int MEM_LATENCY = 3
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         write_en,
    input  access_size_t type_control,
    input  addr_t        addr,
    input  word_t        din,
    output word_t        dout,
    output logic         stall
);

    line_mem_if mem_bus ();

    data_cache u_cache (
        .clk          (clk),
        .rst          (rst),
        .write_en     (write_en),
        .type_control (type_control),
        .addr         (addr),
        .din          (din),
        .dout         (dout),
        .stall        (stall),
        .mem          (mem_bus)
    );

    line_memory #(
        .MEM_LATENCY (MEM_LATENCY)
    ) u_memory (
        .clk (clk),
        .rst (rst),
        .mem (mem_bus)
    );

endmodule

/* design/data_cache.sv */
module data_cache import dcache_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         write_en,
    input  access_size_t type_control,
    input  addr_t        addr,
    input  word_t        din,
    output word_t        dout,
    output logic         stall,
    line_mem_if.cache    mem
);

    logic                  access;
    logic                  accept;
    logic [1:0]            word_off;
    logic [1:0]            byte_off;
    logic [3:0]            byte_mask;
    logic [line_bytes-1:0] line_mask;
    word_t                 store_word;
    word_t                 load_word;
    logic                  hit;
    logic                  hit_way;
    line_t                 hit_line;
    logic                  victim_way;
    logic                  victim_dirty;
    addr_t                 victim_addr;
    line_t                 victim_line;
    logic                  fill_en;
    line_t                 fill_line;

    assign access   = write_en || (type_control != size_none);
    assign accept   = access && !stall;
    assign word_off = addr[index_lsb-1:word_lsb];
    assign byte_off = addr[word_lsb-1:0];

    // lanes and replicated data for stores, low address bits dropped as needed
    always_comb begin
        case (type_control)
            size_byte: begin
                byte_mask  = 4'b0001 << byte_off;
                store_word = {4{din[7:0]}};
            end
            size_half: begin
                byte_mask  = 4'b0011 << {byte_off[1], 1'b0};
                store_word = {2{din[15:0]}};
            end
            // a store flagged size_none writes the full word
            default: begin
                byte_mask  = 4'b1111;
                store_word = din;
            end
        endcase
    end

    assign line_mask = {{(line_bytes - 4){1'b0}}, byte_mask} << {word_off, 2'b00};

    // load lane select, zero extended
    assign load_word = hit_line[{word_off, 5'b00000} +: 32];

    always_comb begin
        case (type_control)
            size_byte: dout = {24'b0, load_word[{byte_off, 3'b000} +: 8]};
            size_half: dout = {16'b0, load_word[{byte_off[1], 4'b0000} +: 16]};
            default:   dout = load_word;
        endcase
    end

    dcache_store u_store (
        .clk          (clk),
        .rst          (rst),
        .lookup_addr  (addr),
        .wr_en        (accept && write_en),
        .wr_way       (fill_en ? victim_way : hit_way),
        .wr_word_mask (line_mask),
        .wr_line      (fill_en ? fill_line : {4{store_word}}),
        .fill_en      (fill_en),
        .touch_en     (accept),
        .hit          (hit),
        .hit_way      (hit_way),
        .hit_line     (hit_line),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_addr  (victim_addr),
        .victim_line  (victim_line)
    );

    dcache_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .access       (access),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .victim_addr  (victim_addr),
        .victim_line  (victim_line),
        .lookup_addr  (addr),
        .stall        (stall),
        .fill_en      (fill_en),
        .fill_line    (fill_line),
        .mem          (mem)
    );

endmodule

/* design/dcache_ctrl.sv */
module dcache_ctrl import dcache_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       access,
    input  logic       hit,
    input  logic       victim_dirty,
    input  addr_t      victim_addr,
    input  line_t      victim_line,
    input  addr_t      lookup_addr,
    output logic       stall,
    output logic       fill_en,
    output line_t      fill_line,
    line_mem_if.cache  mem
);

    ctrl_state_t state;
    ctrl_state_t next_state;
    logic        miss;

    assign miss = access && !hit;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (miss) begin
                    // dirty victim goes out before the refill
                    if (victim_dirty) begin
                        next_state = st_writeback;
                    end else begin
                        next_state = st_allocate;
                    end
                end
            end
            st_writeback: begin
                if (mem.mem_ready) begin
                    next_state = st_allocate;
                end
            end
            st_allocate: begin
                if (mem.mem_ready) begin
                    next_state = st_update;
                end
            end
            st_update: begin
                next_state = st_idle;
            end
            default: begin
                next_state = st_idle;
            end
        endcase
    end

    // held access stays stalled until the refilled line hits
    assign stall = (state != st_idle) || miss;

    // requests follow the state, so they drop the cycle after ready
    assign mem.mem_write = (state == st_writeback);
    assign mem.mem_read  = (state == st_allocate);
    assign mem.mem_wdata = victim_line;

    always_comb begin
        if (state == st_writeback) begin
            mem.mem_addr = victim_addr;
        end else begin
            mem.mem_addr = line_base(lookup_addr);
        end
    end

    // capture the fetched line for the update cycle
    always_ff @(posedge clk) begin
        if (state == st_allocate && mem.mem_ready) begin
            fill_line <= mem.mem_rdata;
        end
    end

    assign fill_en = (state == st_update);

endmodule

/* design/dcache_pkg.sv */
package dcache_pkg;

    // cache geometry
    localparam int num_sets   = 128;
    localparam int num_ways   = 2;
    localparam int tag_bits   = 21;
    localparam int index_bits = 7;
    localparam int line_bits  = 128;
    localparam int line_bytes = line_bits / 8;

    // address split: tag | index | word offset | byte offset
    localparam int tag_lsb   = 11;
    localparam int index_lsb = 4;
    localparam int word_lsb  = 2;

    typedef logic [31:0]           addr_t;
    typedef logic [31:0]           word_t;
    typedef logic [line_bits-1:0]  line_t;
    typedef logic [tag_bits-1:0]   tag_t;
    typedef logic [index_bits-1:0] index_t;

    // encoding matches the processor's type_control field
    typedef enum logic [1:0] {
        size_byte,
        size_half,
        size_word,
        size_none
    } access_size_t;

    typedef enum logic [1:0] {
        st_idle,
        st_writeback,
        st_allocate,
        st_update
    } ctrl_state_t;

    function automatic tag_t addr_tag(addr_t a);
        return a[31:tag_lsb];
    endfunction

    function automatic index_t addr_index(addr_t a);
        return a[tag_lsb-1:index_lsb];
    endfunction

    // first byte of the line holding a
    function automatic addr_t line_base(addr_t a);
        return {a[31:index_lsb], {index_lsb{1'b0}}};
    endfunction

endpackage

/* design/dcache_store.sv */
module dcache_store import dcache_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  addr_t                 lookup_addr,
    input  logic                  wr_en,
    input  logic                  wr_way,
    input  logic [line_bytes-1:0] wr_word_mask,
    input  line_t                 wr_line,
    input  logic                  fill_en,
    input  logic                  touch_en,
    output logic                  hit,
    output logic                  hit_way,
    output line_t                 hit_line,
    output logic                  victim_way,
    output logic                  victim_dirty,
    output addr_t                 victim_addr,
    output line_t                 victim_line
);

    // status bits, cleared by reset
    logic [num_sets-1:0][num_ways-1:0] valid_bits;
    logic [num_sets-1:0][num_ways-1:0] dirty_bits;
    logic [num_sets-1:0]               lru_bits;

    // tag and data arrays
    tag_t  tag_mem  [num_sets][num_ways];
    line_t data_mem [num_sets][num_ways];

    tag_t                lookup_tag;
    index_t              index;
    logic [num_ways-1:0] way_match;

    assign lookup_tag = addr_tag(lookup_addr);
    assign index      = addr_index(lookup_addr);

    // compare both ways of the indexed set
    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            way_match[w] = valid_bits[index][w] && (tag_mem[index][w] == lookup_tag);
        end
    end

    assign hit      = |way_match;
    assign hit_way  = way_match[1];
    assign hit_line = data_mem[index][hit_way];

    // lru bit names the way to replace
    assign victim_way   = lru_bits[index];
    assign victim_dirty = valid_bits[index][victim_way] && dirty_bits[index][victim_way];
    assign victim_addr  = {tag_mem[index][victim_way], index, {index_lsb{1'b0}}};
    assign victim_line  = data_mem[index][victim_way];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_bits <= '0;
            dirty_bits <= '0;
            lru_bits   <= '0;
        end else begin
            if (fill_en) begin
                // refilled line arrives clean
                valid_bits[index][wr_way] <= 1'b1;
                dirty_bits[index][wr_way] <= 1'b0;
            end else if (wr_en) begin
                dirty_bits[index][wr_way] <= 1'b1;
            end
            if (touch_en) begin
                lru_bits[index] <= ~hit_way;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_mem[index][wr_way]  <= lookup_tag;
            data_mem[index][wr_way] <= wr_line;
        end else if (wr_en) begin
            // byte enables cover the whole line
            for (int b = 0; b < line_bytes; b++) begin
                if (wr_word_mask[b]) begin
                    data_mem[index][wr_way][b*8 +: 8] <= wr_line[b*8 +: 8];
                end
            end
        end
    end

endmodule

/* design/line_mem_if.sv */
interface line_mem_if import dcache_pkg::*; ();

    logic  mem_read;
    logic  mem_write;
    addr_t mem_addr;
    line_t mem_wdata;
    line_t mem_rdata;
    logic  mem_ready;

    modport cache (
        output mem_read,
        output mem_write,
        output mem_addr,
        output mem_wdata,
        input  mem_rdata,
        input  mem_ready
    );

    modport memory (
        input  mem_read,
        input  mem_write,
        input  mem_addr,
        input  mem_wdata,
        output mem_rdata,
        output mem_ready
    );

endinterface

/* design/line_memory.sv */
module line_memory import dcache_pkg::*; #(
    parameter int MEM_LATENCY = 3
) (
    input  logic       clk,
    input  logic       rst,
    line_mem_if.memory mem
);

    localparam int num_lines = 4096;
    localparam int cnt_bits  = (MEM_LATENCY > 1) ? $clog2(MEM_LATENCY) : 1;

    line_t               mem_array [num_lines];
    logic [11:0]         line_idx;
    logic                req;
    logic [cnt_bits-1:0] wait_cnt;

    // contents survive reset
    initial begin
        for (int i = 0; i < num_lines; i++) begin
            mem_array[i] = '0;
        end
    end

    // upper address bits wrap onto the same 64 KB
    assign line_idx = mem.mem_addr[15:index_lsb];
    assign req      = mem.mem_read || mem.mem_write;

    // ready after MEM_LATENCY cycles of a held request
    assign mem.mem_ready = req && (wait_cnt == cnt_bits'(MEM_LATENCY - 1));
    assign mem.mem_rdata = mem_array[line_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wait_cnt <= '0;
        end else if (!req || mem.mem_ready) begin
            wait_cnt <= '0;
        end else begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (mem.mem_write && mem.mem_ready) begin
            mem_array[line_idx] <= mem.mem_wdata;
        end
    end

endmodule
